// File: ldu_dq.f
verilog/ldu_dq_pkg.sv
verilog/ldu_dq_dispatch_alloc.sv
verilog/ldu_dq_wakeup_kill.sv
verilog/ldu_dq_entries.sv
verilog/ldu_dq.sv
bench/tb_ldu_dq.sv

// File: Makefile
# Verilator build and run of the load unit dispatch queue testbench

VERILATOR ?= verilator
TOP       ?= tb_ldu_dq
FILELIST  ?= ldu_dq.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Simulation failed
PASS_MSG  ?= Simulation completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST) Makefile
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "run failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "run ended without a result, see $(LOG)"; exit 1; \
	fi
	@echo "run passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/tb_ldu_dq.sv
// ----------------------------------------------------------
// testbench for the load unit dispatch queue
// clock and reset, stimulus/expected table, value compare
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_ldu_dq;

    // one table row: stimulus, then expected values
    typedef struct packed {
        logic [3:0]  att;
        logic [31:0] ids;
        logic [3:0]  a_rdy;
        logic [1:0]  rdy;
        logic [7:0]  wb;
        logic [14:0] kill;
        logic [3:0]  ack;
        logic [7:0]  lid;
        logic        hv;
        logic        lv;
        logic        lrdy;
        logic        lkill;
    } row_t;

    logic CLK;
    logic nRST;

    logic                   [ldu_dq_pkg::DISPATCH_WAYS-1:0] dispatch_attempt_by_way;
    ldu_dq_pkg::ldu_op_e    [ldu_dq_pkg::DISPATCH_WAYS-1:0] dispatch_op_by_way;
    ldu_dq_pkg::imm12_t     [ldu_dq_pkg::DISPATCH_WAYS-1:0] dispatch_imm12_by_way;
    ldu_dq_pkg::pr_t        [ldu_dq_pkg::DISPATCH_WAYS-1:0] dispatch_A_PR_by_way;
    logic                   [ldu_dq_pkg::DISPATCH_WAYS-1:0] dispatch_A_ready_by_way;
    logic                   [ldu_dq_pkg::DISPATCH_WAYS-1:0] dispatch_A_is_zero_by_way;
    ldu_dq_pkg::pr_t        [ldu_dq_pkg::DISPATCH_WAYS-1:0] dispatch_dest_PR_by_way;
    ldu_dq_pkg::rob_index_t [ldu_dq_pkg::DISPATCH_WAYS-1:0] dispatch_ROB_index_by_way;
    logic                   [ldu_dq_pkg::DISPATCH_WAYS-1:0] dispatch_ack_by_way;

    logic                   [ldu_dq_pkg::PRF_BANK_COUNT-1:0] WB_bus_valid_by_bank;
    ldu_dq_pkg::upper_pr_t  [ldu_dq_pkg::PRF_BANK_COUNT-1:0] WB_bus_upper_PR_by_bank;

    logic                   ldu_cq_enq_valid;
    logic                   ldu_cq_enq_killed;
    ldu_dq_pkg::ldu_op_e    ldu_cq_enq_op;
    ldu_dq_pkg::pr_t        ldu_cq_enq_dest_PR;
    ldu_dq_pkg::rob_index_t ldu_cq_enq_ROB_index;
    logic                   ldu_cq_enq_ready;

    logic                   ldu_iq_enq_valid;
    ldu_dq_pkg::ldu_op_e    ldu_iq_enq_op;
    ldu_dq_pkg::imm12_t     ldu_iq_enq_imm12;
    ldu_dq_pkg::pr_t        ldu_iq_enq_A_PR;
    logic                   ldu_iq_enq_A_ready;
    logic                   ldu_iq_enq_A_is_zero;
    logic                   ldu_iq_enq_ready;

    logic                   rob_kill_valid;
    ldu_dq_pkg::rob_index_t rob_kill_abs_head_index;
    ldu_dq_pkg::rob_index_t rob_kill_rel_kill_younger_index;

    row_t        rows[$];
    string       names[$];
    integer      seed;
    logic [31:0] rnd;
    logic [6:0]  rob_base;
    int          wait_cycles;

    ldu_dq i_dut (.*);

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    initial begin
        nRST = 1'b0;
        repeat (10) @(posedge CLK);
        #10;
        nRST = 1'b1;
    end

    // ------------------------------------------------------------
    // op field model, one op per id

    function automatic ldu_dq_pkg::ldu_op_e op_of(input logic [7:0] id);
        case (id % 8'd5)
            8'd0:    op_of = ldu_dq_pkg::LDU_LB;
            8'd1:    op_of = ldu_dq_pkg::LDU_LH;
            8'd2:    op_of = ldu_dq_pkg::LDU_LW;
            8'd3:    op_of = ldu_dq_pkg::LDU_LBU;
            default: op_of = ldu_dq_pkg::LDU_LHU;
        endcase
    endfunction

    task automatic compare_value(input string test, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s %s: expected %0h, actual %0h", test, field, expected, actual);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // flags are {head valid, launch valid, A_ready, killed}
    task automatic add_row(input string name, input logic [3:0] att, input logic [31:0] ids,
                           input logic [3:0] a_rdy, input logic [1:0] rdy, input logic [7:0] wb,
                           input logic [14:0] kill, input logic [3:0] ack,
                           input logic [7:0] lid, input logic [3:0] flags);
        row_t r;

        r = {att, ids, a_rdy, rdy, wb, kill, ack, lid, flags};
        rows.push_back(r);
        names.push_back(name);
    endtask

    // ------------------------------------------------------------
    // table: name, attempts, way ids, A_ready by way, {cq,iq} ready,
    // wb {valid,bank,tag}, kill {valid,head,rel}, acks, head id, flags
    // A_PR and dest_PR of an op are its id, so id 8'h11 sits on bank 1 with tag 4

    task automatic load_table();
        add_row("reset_acks", 4'hf, 32'h04030201, 4'hf, 2'b00, 8'h00, 15'h0, 4'hf, 8'h00, 4'b0000);
        add_row("full_hold", 4'h3, 32'h00000605, 4'hf, 2'b00, 8'h00, 15'h0, 4'h0, 8'h01, 4'b1010);
        add_row("order_1", 4'h0, 32'h0, 4'hf, 2'b11, 8'h00, 15'h0, 4'h0, 8'h01, 4'b1110);
        add_row("order_2", 4'h0, 32'h0, 4'hf, 2'b11, 8'h00, 15'h0, 4'h0, 8'h02, 4'b1110);
        add_row("bp_cq_low", 4'h0, 32'h0, 4'hf, 2'b01, 8'h00, 15'h0, 4'h0, 8'h03, 4'b1010);
        add_row("bp_iq_low", 4'h0, 32'h0, 4'hf, 2'b10, 8'h00, 15'h0, 4'h0, 8'h03, 4'b1010);
        add_row("bp_resume", 4'h0, 32'h0, 4'hf, 2'b11, 8'h00, 15'h0, 4'h0, 8'h03, 4'b1110);
        add_row("order_ways", 4'ha, 32'h08000700, 4'hf, 2'b11, 8'h00, 15'h0, 4'ha, 8'h04, 4'b1110);
        add_row("order_w1", 4'h0, 32'h0, 4'hf, 2'b11, 8'h00, 15'h0, 4'h0, 8'h07, 4'b1110);
        add_row("order_w3", 4'h0, 32'h0, 4'hf, 2'b11, 8'h00, 15'h0, 4'h0, 8'h08, 4'b1110);
        add_row("drained", 4'h0, 32'h0, 4'hf, 2'b11, 8'h00, 15'h0, 4'h0, 8'h00, 4'b0000);
        // three held, then one slot left
        add_row("alloc_three", 4'h7, 32'h000b0a09, 4'hf, 2'b00, 8'h00, 15'h0, 4'h7, 8'h00, 4'b0000);
        add_row("alloc_low", 4'h6, 32'h000d0c00, 4'hf, 2'b00, 8'h00, 15'h0, 4'h2, 8'h09, 4'b1010);
        add_row("alloc_full", 4'hf, 32'h11100f0e, 4'hf, 2'b00, 8'h00, 15'h0, 4'h0, 8'h09, 4'b1010);
        add_row("alloc_freed", 4'h1, 32'h0000000e, 4'hf, 2'b11, 8'h00, 15'h0, 4'h0, 8'h09, 4'b1110);
        add_row("drain_a", 4'h0, 32'h0, 4'hf, 2'b11, 8'h00, 15'h0, 4'h0, 8'h0a, 4'b1110);
        add_row("drain_b", 4'h0, 32'h0, 4'hf, 2'b11, 8'h00, 15'h0, 4'h0, 8'h0b, 4'b1110);
        add_row("drain_c", 4'h0, 32'h0, 4'hf, 2'b11, 8'h00, 15'h0, 4'h0, 8'h0c, 4'b1110);
        // wakeup on banks 0 to 3, all with tag 4
        add_row("wk_fill", 4'hf, 32'h13121110, 4'h0, 2'b00, 8'h00, 15'h0, 4'hf, 8'h00, 4'b0000);
        add_row("wk_bank", 4'h0, 32'h0, 4'h0, 2'b00, {1'b1, 2'd1, 5'h04}, 15'h0,
                4'h0, 8'h10, 4'b1000);
        add_row("wk_tag", 4'h0, 32'h0, 4'h0, 2'b00, {1'b1, 2'd0, 5'h05}, 15'h0,
                4'h0, 8'h10, 4'b1000);
        add_row("wk_wait", 4'h0, 32'h0, 4'h0, 2'b00, {1'b1, 2'd0, 5'h04}, 15'h0,
                4'h0, 8'h10, 4'b1010);
        add_row("wk_head", 4'h0, 32'h0, 4'h0, 2'b11, 8'h00, 15'h0, 4'h0, 8'h10, 4'b1110);
        add_row("wk_early", 4'h0, 32'h0, 4'h0, 2'b11, 8'h00, 15'h0, 4'h0, 8'h11, 4'b1110);
        add_row("wk_late", 4'h0, 32'h0, 4'h0, 2'b11, {1'b1, 2'd2, 5'h04}, 15'h0,
                4'h0, 8'h12, 4'b1110);
        add_row("wk_never", 4'h0, 32'h0, 4'h0, 2'b11, 8'h00, 15'h0, 4'h0, 8'h13, 4'b1100);
        // ages 0 to 3 against head 8'h20, younger than 1 killed
        add_row("kill_fill", 4'hf, 32'h23222120, 4'hf, 2'b00, 8'h00, 15'h0, 4'hf, 8'h00, 4'b0000);
        add_row("kill_mark", 4'h0, 32'h0, 4'hf, 2'b00, 8'h00, {1'b1, 7'h20, 7'h01},
                4'h0, 8'h20, 4'b1010);
        add_row("kill_old0", 4'h0, 32'h0, 4'hf, 2'b11, 8'h00, 15'h0, 4'h0, 8'h20, 4'b1110);
        add_row("kill_old1", 4'h0, 32'h0, 4'hf, 2'b11, 8'h00, 15'h0, 4'h0, 8'h21, 4'b1110);
        add_row("kill_yng0", 4'h0, 32'h0, 4'hf, 2'b11, 8'h00, 15'h0, 4'h0, 8'h22, 4'b1111);
        add_row("kill_yng1", 4'h0, 32'h0, 4'hf, 2'b11, 8'h00, 15'h0, 4'h0, 8'h23, 4'b1111);
        // head 7f wraps, ids 1 and 2 have ages 2 and 3
        add_row("wrap_fill", 4'h3, 32'h00000201, 4'hf, 2'b00, 8'h00, 15'h0, 4'h3, 8'h00, 4'b0000);
        add_row("wrap_old", 4'h0, 32'h0, 4'hf, 2'b11, 8'h00, {1'b1, 7'h7f, 7'h02},
                4'h0, 8'h01, 4'b1110);
        add_row("wrap_young", 4'h0, 32'h0, 4'hf, 2'b11, 8'h00, 15'h0, 4'h0, 8'h02, 4'b1111);
        add_row("final_empty", 4'h0, 32'h0, 4'hf, 2'b11, 8'h00, 15'h0, 4'h0, 8'h00, 4'b0000);
    endtask

    // ------------------------------------------------------------
    // drive and check one row

    task automatic apply_row(input row_t r);
        logic [7:0] id;

        dispatch_attempt_by_way = r.att;
        for (int w = 0; w < ldu_dq_pkg::DISPATCH_WAYS; w++) begin
            id = r.ids[w*8 +: 8];
            dispatch_op_by_way[w]        = op_of(id);
            dispatch_imm12_by_way[w]     = {4'ha, id};
            dispatch_A_PR_by_way[w]      = id[6:0];
            dispatch_A_ready_by_way[w]   = r.a_rdy[w];
            // A_is_zero of an op is the low bit of its id
            dispatch_A_is_zero_by_way[w] = id[0];
            dispatch_dest_PR_by_way[w]   = id[6:0];
            dispatch_ROB_index_by_way[w] = rob_base + id[6:0];
        end
        // same tag on every bank, valid only on the chosen one
        for (int b = 0; b < ldu_dq_pkg::PRF_BANK_COUNT; b++) begin
            WB_bus_upper_PR_by_bank[b] = r.wb[4:0];
        end
        WB_bus_valid_by_bank = r.wb[7] ? (4'b0001 << r.wb[6:5]) : 4'b0000;
        {ldu_cq_enq_ready, ldu_iq_enq_ready} = r.rdy;
        rob_kill_valid                  = r.kill[14];
        rob_kill_abs_head_index         = rob_base + r.kill[13:7];
        rob_kill_rel_kill_younger_index = r.kill[6:0];
    endtask

    task automatic check_row(input string test, input row_t r);
        ldu_dq_pkg::rob_index_t exp_rob;

        exp_rob = rob_base + r.lid[6:0];
        compare_value(test, "ack", 32'(r.ack), 32'(dispatch_ack_by_way));
        compare_value(test, "cq_valid", 32'(r.lv), 32'(ldu_cq_enq_valid));
        compare_value(test, "iq_valid", 32'(r.lv), 32'(ldu_iq_enq_valid));
        if (r.hv) begin
            compare_value(test, "cq_op", 32'(op_of(r.lid)), 32'(ldu_cq_enq_op));
            compare_value(test, "iq_op", 32'(op_of(r.lid)), 32'(ldu_iq_enq_op));
            compare_value(test, "dest_PR", 32'(r.lid[6:0]), 32'(ldu_cq_enq_dest_PR));
            compare_value(test, "ROB_index", 32'(exp_rob), 32'(ldu_cq_enq_ROB_index));
            compare_value(test, "imm12", 32'({4'ha, r.lid}), 32'(ldu_iq_enq_imm12));
            compare_value(test, "A_PR", 32'(r.lid[6:0]), 32'(ldu_iq_enq_A_PR));
            compare_value(test, "A_ready", 32'(r.lrdy), 32'(ldu_iq_enq_A_ready));
            compare_value(test, "A_is_zero", 32'(r.lid[0]), 32'(ldu_iq_enq_A_is_zero));
            compare_value(test, "killed", 32'(r.lkill), 32'(ldu_cq_enq_killed));
        end
    endtask

    // ------------------------------------------------------------
    // main sequence

    initial begin
        seed = 32'h1fe42d77;
        rnd = $random(seed);
        // random ROB base, all ROB indices and kill heads are offsets from it
        rob_base = rnd[6:0];
        apply_row('0);
        load_table();

        wait_cycles = 0;
        while (nRST !== 1'b1) begin
            @(posedge CLK);
            wait_cycles++;
            if (wait_cycles > 20) begin
                $display("reset was not released within 20 clock cycles");
                $display("Simulation failed");
                $fatal(1, "reset timeout");
            end
        end

        for (int i = 0; i < rows.size(); i++) begin
            @(posedge CLK);
            #10;
            apply_row(rows[i]);
            #50;
            check_row(names[i], rows[i]);
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/ldu_dq.sv
// ----------------------------------------------------------
// load unit dispatch queue top level
// allocator, entry array and wakeup/kill checker
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module ldu_dq (
    input  logic CLK,
    input  logic nRST,

    // dispatch by way
    input  logic                   [ldu_dq_pkg::DISPATCH_WAYS-1:0] dispatch_attempt_by_way,
    input  ldu_dq_pkg::ldu_op_e    [ldu_dq_pkg::DISPATCH_WAYS-1:0] dispatch_op_by_way,
    input  ldu_dq_pkg::imm12_t     [ldu_dq_pkg::DISPATCH_WAYS-1:0] dispatch_imm12_by_way,
    input  ldu_dq_pkg::pr_t        [ldu_dq_pkg::DISPATCH_WAYS-1:0] dispatch_A_PR_by_way,
    input  logic                   [ldu_dq_pkg::DISPATCH_WAYS-1:0] dispatch_A_ready_by_way,
    input  logic                   [ldu_dq_pkg::DISPATCH_WAYS-1:0] dispatch_A_is_zero_by_way,
    input  ldu_dq_pkg::pr_t        [ldu_dq_pkg::DISPATCH_WAYS-1:0] dispatch_dest_PR_by_way,
    input  ldu_dq_pkg::rob_index_t [ldu_dq_pkg::DISPATCH_WAYS-1:0] dispatch_ROB_index_by_way,
    output logic                   [ldu_dq_pkg::DISPATCH_WAYS-1:0] dispatch_ack_by_way,

    // writeback bus by bank
    input  logic                   [ldu_dq_pkg::PRF_BANK_COUNT-1:0] WB_bus_valid_by_bank,
    input  ldu_dq_pkg::upper_pr_t  [ldu_dq_pkg::PRF_BANK_COUNT-1:0] WB_bus_upper_PR_by_bank,

    // central queue launch
    output logic                   ldu_cq_enq_valid,
    output logic                   ldu_cq_enq_killed,
    output ldu_dq_pkg::ldu_op_e    ldu_cq_enq_op,
    output ldu_dq_pkg::pr_t        ldu_cq_enq_dest_PR,
    output ldu_dq_pkg::rob_index_t ldu_cq_enq_ROB_index,
    input  logic                   ldu_cq_enq_ready,

    // issue queue launch
    output logic                   ldu_iq_enq_valid,
    output ldu_dq_pkg::ldu_op_e    ldu_iq_enq_op,
    output ldu_dq_pkg::imm12_t     ldu_iq_enq_imm12,
    output ldu_dq_pkg::pr_t        ldu_iq_enq_A_PR,
    output logic                   ldu_iq_enq_A_ready,
    output logic                   ldu_iq_enq_A_is_zero,
    input  logic                   ldu_iq_enq_ready,

    // reorder buffer kill
    input  logic                   rob_kill_valid,
    input  ldu_dq_pkg::rob_index_t rob_kill_abs_head_index,
    input  ldu_dq_pkg::rob_index_t rob_kill_rel_kill_younger_index
);

    // allocator to entry array
    ldu_dq_pkg::entry_mask_t                             dispatch_valid_by_entry;
    ldu_dq_pkg::ldu_op_e    [ldu_dq_pkg::DQ_ENTRIES-1:0] dispatch_op_by_entry;
    ldu_dq_pkg::imm12_t     [ldu_dq_pkg::DQ_ENTRIES-1:0] dispatch_imm12_by_entry;
    ldu_dq_pkg::pr_t        [ldu_dq_pkg::DQ_ENTRIES-1:0] dispatch_A_PR_by_entry;
    ldu_dq_pkg::entry_mask_t                             dispatch_A_ready_by_entry;
    ldu_dq_pkg::entry_mask_t                             dispatch_A_is_zero_by_entry;
    ldu_dq_pkg::pr_t        [ldu_dq_pkg::DQ_ENTRIES-1:0] dispatch_dest_PR_by_entry;
    ldu_dq_pkg::rob_index_t [ldu_dq_pkg::DQ_ENTRIES-1:0] dispatch_ROB_index_by_entry;

    // checker to entry array
    ldu_dq_pkg::entry_mask_t new_A_ready_by_entry;
    ldu_dq_pkg::entry_mask_t new_killed_by_entry;

    // entry state fed back
    ldu_dq_pkg::entry_mask_t                             valid_by_entry;
    ldu_dq_pkg::pr_t        [ldu_dq_pkg::DQ_ENTRIES-1:0] A_PR_by_entry;
    ldu_dq_pkg::rob_index_t [ldu_dq_pkg::DQ_ENTRIES-1:0] ROB_index_by_entry;

    // port names match across the three blocks
    ldu_dq_dispatch_alloc i_alloc (.*);

    ldu_dq_wakeup_kill i_wakeup_kill (.*);

    ldu_dq_entries i_entries (.*);

endmodule

`default_nettype wire

// File: verilog/ldu_dq_entries.sv
// ----------------------------------------------------------
// dispatch queue entry array
// collapsing registers, sticky ready/killed, head launch
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module ldu_dq_entries (
    input  logic CLK,
    input  logic nRST,

    // dispatch by entry
    input  ldu_dq_pkg::entry_mask_t                             dispatch_valid_by_entry,
    input  ldu_dq_pkg::ldu_op_e    [ldu_dq_pkg::DQ_ENTRIES-1:0] dispatch_op_by_entry,
    input  ldu_dq_pkg::imm12_t     [ldu_dq_pkg::DQ_ENTRIES-1:0] dispatch_imm12_by_entry,
    input  ldu_dq_pkg::pr_t        [ldu_dq_pkg::DQ_ENTRIES-1:0] dispatch_A_PR_by_entry,
    input  ldu_dq_pkg::entry_mask_t                             dispatch_A_ready_by_entry,
    input  ldu_dq_pkg::entry_mask_t                             dispatch_A_is_zero_by_entry,
    input  ldu_dq_pkg::pr_t        [ldu_dq_pkg::DQ_ENTRIES-1:0] dispatch_dest_PR_by_entry,
    input  ldu_dq_pkg::rob_index_t [ldu_dq_pkg::DQ_ENTRIES-1:0] dispatch_ROB_index_by_entry,

    // checker results
    input  ldu_dq_pkg::entry_mask_t new_A_ready_by_entry,
    input  ldu_dq_pkg::entry_mask_t new_killed_by_entry,

    // entry state
    output ldu_dq_pkg::entry_mask_t                             valid_by_entry,
    output ldu_dq_pkg::pr_t        [ldu_dq_pkg::DQ_ENTRIES-1:0] A_PR_by_entry,
    output ldu_dq_pkg::rob_index_t [ldu_dq_pkg::DQ_ENTRIES-1:0] ROB_index_by_entry,

    // central queue launch
    output logic                   ldu_cq_enq_valid,
    output logic                   ldu_cq_enq_killed,
    output ldu_dq_pkg::ldu_op_e    ldu_cq_enq_op,
    output ldu_dq_pkg::pr_t        ldu_cq_enq_dest_PR,
    output ldu_dq_pkg::rob_index_t ldu_cq_enq_ROB_index,
    input  logic                   ldu_cq_enq_ready,

    // issue queue launch
    output logic                   ldu_iq_enq_valid,
    output ldu_dq_pkg::ldu_op_e    ldu_iq_enq_op,
    output ldu_dq_pkg::imm12_t     ldu_iq_enq_imm12,
    output ldu_dq_pkg::pr_t        ldu_iq_enq_A_PR,
    output logic                   ldu_iq_enq_A_ready,
    output logic                   ldu_iq_enq_A_is_zero,
    input  logic                   ldu_iq_enq_ready
);

    ldu_dq_pkg::entry_mask_t                             killed_by_entry;
    ldu_dq_pkg::entry_mask_t                             A_ready_by_entry;
    ldu_dq_pkg::entry_mask_t                             A_is_zero_by_entry;
    ldu_dq_pkg::ldu_op_e    [ldu_dq_pkg::DQ_ENTRIES-1:0] op_by_entry;
    ldu_dq_pkg::imm12_t     [ldu_dq_pkg::DQ_ENTRIES-1:0] imm12_by_entry;
    ldu_dq_pkg::pr_t        [ldu_dq_pkg::DQ_ENTRIES-1:0] dest_PR_by_entry;

    // slot value if nothing launched; slot DQ_ENTRIES is the empty one above the top
    logic                   [ldu_dq_pkg::DQ_ENTRIES:0]   take_valid;
    logic                   [ldu_dq_pkg::DQ_ENTRIES:0]   take_killed;
    logic                   [ldu_dq_pkg::DQ_ENTRIES:0]   take_A_ready;
    logic                   [ldu_dq_pkg::DQ_ENTRIES:0]   take_A_is_zero;
    ldu_dq_pkg::ldu_op_e    [ldu_dq_pkg::DQ_ENTRIES:0]   take_op;
    ldu_dq_pkg::imm12_t     [ldu_dq_pkg::DQ_ENTRIES:0]   take_imm12;
    ldu_dq_pkg::pr_t        [ldu_dq_pkg::DQ_ENTRIES:0]   take_A_PR;
    ldu_dq_pkg::pr_t        [ldu_dq_pkg::DQ_ENTRIES:0]   take_dest_PR;
    ldu_dq_pkg::rob_index_t [ldu_dq_pkg::DQ_ENTRIES:0]   take_ROB_index;

    logic launching;

    // ------------------------------------------------------------
    // head launch

    assign launching = valid_by_entry[0] & ldu_cq_enq_ready & ldu_iq_enq_ready;

    assign ldu_cq_enq_valid     = launching;
    assign ldu_cq_enq_killed    = killed_by_entry[0] | new_killed_by_entry[0];
    assign ldu_cq_enq_op        = op_by_entry[0];
    assign ldu_cq_enq_dest_PR   = dest_PR_by_entry[0];
    assign ldu_cq_enq_ROB_index = ROB_index_by_entry[0];

    assign ldu_iq_enq_valid     = launching;
    assign ldu_iq_enq_op        = op_by_entry[0];
    assign ldu_iq_enq_imm12     = imm12_by_entry[0];
    assign ldu_iq_enq_A_PR      = A_PR_by_entry[0];
    assign ldu_iq_enq_A_ready   = A_ready_by_entry[0] | new_A_ready_by_entry[0];
    assign ldu_iq_enq_A_is_zero = A_is_zero_by_entry[0];

    // ------------------------------------------------------------
    // per-slot next value: keep a valid entry, else take dispatch

    assign take_valid     = {1'b0, valid_by_entry | dispatch_valid_by_entry};
    assign take_killed    = {1'b0, valid_by_entry & (killed_by_entry | new_killed_by_entry)};
    assign take_A_ready   = {1'b0, (valid_by_entry & (A_ready_by_entry | new_A_ready_by_entry))
                                 | (~valid_by_entry & dispatch_A_ready_by_entry)};
    assign take_A_is_zero = {1'b0, (valid_by_entry & A_is_zero_by_entry)
                                 | (~valid_by_entry & dispatch_A_is_zero_by_entry)};

    always_comb begin
        take_op[ldu_dq_pkg::DQ_ENTRIES]        = ldu_dq_pkg::LDU_LB;
        take_imm12[ldu_dq_pkg::DQ_ENTRIES]     = '0;
        take_A_PR[ldu_dq_pkg::DQ_ENTRIES]      = '0;
        take_dest_PR[ldu_dq_pkg::DQ_ENTRIES]   = '0;
        take_ROB_index[ldu_dq_pkg::DQ_ENTRIES] = '0;
        for (int j = 0; j < ldu_dq_pkg::DQ_ENTRIES; j++) begin
            take_op[j]        = valid_by_entry[j] ? op_by_entry[j] : dispatch_op_by_entry[j];
            take_imm12[j]     = valid_by_entry[j] ? imm12_by_entry[j] : dispatch_imm12_by_entry[j];
            take_A_PR[j]      = valid_by_entry[j] ? A_PR_by_entry[j] : dispatch_A_PR_by_entry[j];
            take_dest_PR[j]   = valid_by_entry[j] ? dest_PR_by_entry[j]
                                                  : dispatch_dest_PR_by_entry[j];
            take_ROB_index[j] = valid_by_entry[j] ? ROB_index_by_entry[j]
                                                  : dispatch_ROB_index_by_entry[j];
        end
    end

    // ------------------------------------------------------------
    // registers, shifted down one slot on launch

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_by_entry <= '0;
        end else begin
            valid_by_entry <= launching ? take_valid[ldu_dq_pkg::DQ_ENTRIES:1]
                                        : take_valid[ldu_dq_pkg::DQ_ENTRIES-1:0];
        end
    end

    always_ff @(posedge CLK) begin
        if (launching) begin
            killed_by_entry    <= take_killed[ldu_dq_pkg::DQ_ENTRIES:1];
            A_ready_by_entry   <= take_A_ready[ldu_dq_pkg::DQ_ENTRIES:1];
            A_is_zero_by_entry <= take_A_is_zero[ldu_dq_pkg::DQ_ENTRIES:1];
            op_by_entry        <= take_op[ldu_dq_pkg::DQ_ENTRIES:1];
            imm12_by_entry     <= take_imm12[ldu_dq_pkg::DQ_ENTRIES:1];
            A_PR_by_entry      <= take_A_PR[ldu_dq_pkg::DQ_ENTRIES:1];
            dest_PR_by_entry   <= take_dest_PR[ldu_dq_pkg::DQ_ENTRIES:1];
            ROB_index_by_entry <= take_ROB_index[ldu_dq_pkg::DQ_ENTRIES:1];
        end else begin
            killed_by_entry    <= take_killed[ldu_dq_pkg::DQ_ENTRIES-1:0];
            A_ready_by_entry   <= take_A_ready[ldu_dq_pkg::DQ_ENTRIES-1:0];
            A_is_zero_by_entry <= take_A_is_zero[ldu_dq_pkg::DQ_ENTRIES-1:0];
            op_by_entry        <= take_op[ldu_dq_pkg::DQ_ENTRIES-1:0];
            imm12_by_entry     <= take_imm12[ldu_dq_pkg::DQ_ENTRIES-1:0];
            A_PR_by_entry      <= take_A_PR[ldu_dq_pkg::DQ_ENTRIES-1:0];
            dest_PR_by_entry   <= take_dest_PR[ldu_dq_pkg::DQ_ENTRIES-1:0];
            ROB_index_by_entry <= take_ROB_index[ldu_dq_pkg::DQ_ENTRIES-1:0];
        end
    end

    // ------------------------------------------------------------
    // checks

    // occupancy stays packed at the head across collapse and fill
    a_valid_contiguous: assert property (@(posedge CLK) disable iff (!nRST)
        (valid_by_entry & (valid_by_entry + 1'b1)) == '0);

    // a dispatch never lands on a slot that is still held
    a_dispatch_free_slot: assert property (@(posedge CLK) disable iff (!nRST)
        (dispatch_valid_by_entry & valid_by_entry) == '0);

endmodule

`default_nettype wire

// File: verilog/ldu_dq_wakeup_kill.sv
// ----------------------------------------------------------
// per-entry wakeup and kill checker
// writeback bank tag match, modular ROB age compare
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module ldu_dq_wakeup_kill (
    // entry state
    input  ldu_dq_pkg::pr_t        [ldu_dq_pkg::DQ_ENTRIES-1:0]     A_PR_by_entry,
    input  ldu_dq_pkg::rob_index_t [ldu_dq_pkg::DQ_ENTRIES-1:0]     ROB_index_by_entry,

    // writeback bus by bank
    input  logic                   [ldu_dq_pkg::PRF_BANK_COUNT-1:0] WB_bus_valid_by_bank,
    input  ldu_dq_pkg::upper_pr_t  [ldu_dq_pkg::PRF_BANK_COUNT-1:0] WB_bus_upper_PR_by_bank,

    // reorder buffer kill
    input  logic                   rob_kill_valid,
    input  ldu_dq_pkg::rob_index_t rob_kill_abs_head_index,
    input  ldu_dq_pkg::rob_index_t rob_kill_rel_kill_younger_index,

    output ldu_dq_pkg::entry_mask_t new_A_ready_by_entry,
    output ldu_dq_pkg::entry_mask_t new_killed_by_entry
);

    always_comb begin
        logic [ldu_dq_pkg::LOG_PRF_BANK_COUNT-1:0] bank;
        ldu_dq_pkg::rob_index_t                    age;

        for (int i = 0; i < ldu_dq_pkg::DQ_ENTRIES; i++) begin
            // only the bank owning this PR can wake it
            bank = A_PR_by_entry[i][ldu_dq_pkg::LOG_PRF_BANK_COUNT-1:0];
            new_A_ready_by_entry[i] = WB_bus_valid_by_bank[bank]
                & (WB_bus_upper_PR_by_bank[bank]
                   == A_PR_by_entry[i][ldu_dq_pkg::LOG_PR_COUNT-1:ldu_dq_pkg::LOG_PRF_BANK_COUNT]);

            // age relative to ROB head, wraps mod 128
            age = ROB_index_by_entry[i] - rob_kill_abs_head_index;
            new_killed_by_entry[i] = rob_kill_valid & (age > rob_kill_rel_kill_younger_index);
        end
    end

endmodule

`default_nettype wire

// File: verilog/ldu_dq_dispatch_alloc.sv
// ----------------------------------------------------------
// dispatch allocator
// lowest free slot per way in way order, acks,
// one-hot OR-mux of way fields onto entries
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module ldu_dq_dispatch_alloc (
    // dispatch by way
    input  logic                   [ldu_dq_pkg::DISPATCH_WAYS-1:0] dispatch_attempt_by_way,
    input  ldu_dq_pkg::ldu_op_e    [ldu_dq_pkg::DISPATCH_WAYS-1:0] dispatch_op_by_way,
    input  ldu_dq_pkg::imm12_t     [ldu_dq_pkg::DISPATCH_WAYS-1:0] dispatch_imm12_by_way,
    input  ldu_dq_pkg::pr_t        [ldu_dq_pkg::DISPATCH_WAYS-1:0] dispatch_A_PR_by_way,
    input  logic                   [ldu_dq_pkg::DISPATCH_WAYS-1:0] dispatch_A_ready_by_way,
    input  logic                   [ldu_dq_pkg::DISPATCH_WAYS-1:0] dispatch_A_is_zero_by_way,
    input  ldu_dq_pkg::pr_t        [ldu_dq_pkg::DISPATCH_WAYS-1:0] dispatch_dest_PR_by_way,
    input  ldu_dq_pkg::rob_index_t [ldu_dq_pkg::DISPATCH_WAYS-1:0] dispatch_ROB_index_by_way,
    output logic                   [ldu_dq_pkg::DISPATCH_WAYS-1:0] dispatch_ack_by_way,

    // occupancy before this cycle's launch
    input  ldu_dq_pkg::entry_mask_t valid_by_entry,

    // dispatch by entry
    output ldu_dq_pkg::entry_mask_t                             dispatch_valid_by_entry,
    output ldu_dq_pkg::ldu_op_e    [ldu_dq_pkg::DQ_ENTRIES-1:0] dispatch_op_by_entry,
    output ldu_dq_pkg::imm12_t     [ldu_dq_pkg::DQ_ENTRIES-1:0] dispatch_imm12_by_entry,
    output ldu_dq_pkg::pr_t        [ldu_dq_pkg::DQ_ENTRIES-1:0] dispatch_A_PR_by_entry,
    output ldu_dq_pkg::entry_mask_t                             dispatch_A_ready_by_entry,
    output ldu_dq_pkg::entry_mask_t                             dispatch_A_is_zero_by_entry,
    output ldu_dq_pkg::pr_t        [ldu_dq_pkg::DQ_ENTRIES-1:0] dispatch_dest_PR_by_entry,
    output ldu_dq_pkg::rob_index_t [ldu_dq_pkg::DQ_ENTRIES-1:0] dispatch_ROB_index_by_entry
);

    ldu_dq_pkg::entry_mask_t [ldu_dq_pkg::DISPATCH_WAYS-1:0] one_hot_by_way;

    // ------------------------------------------------------------
    // priority encoder chain

    always_comb begin
        ldu_dq_pkg::entry_mask_t open_mask;

        open_mask = ~valid_by_entry;
        for (int w = 0; w < ldu_dq_pkg::DISPATCH_WAYS; w++) begin
            // x & -x isolates the lowest free slot
            one_hot_by_way[w] = dispatch_attempt_by_way[w] ? (open_mask & (-open_mask)) : '0;
            dispatch_ack_by_way[w] = |one_hot_by_way[w];
            open_mask = open_mask & ~one_hot_by_way[w];
        end
    end

    // ------------------------------------------------------------
    // way to entry routing

    always_comb begin
        dispatch_valid_by_entry     = '0;
        dispatch_imm12_by_entry     = '0;
        dispatch_A_PR_by_entry      = '0;
        dispatch_A_ready_by_entry   = '0;
        dispatch_A_is_zero_by_entry = '0;
        dispatch_dest_PR_by_entry   = '0;
        dispatch_ROB_index_by_entry = '0;
        for (int e = 0; e < ldu_dq_pkg::DQ_ENTRIES; e++) begin
            // LDU_LB encodes as zero so it is the OR identity
            dispatch_op_by_entry[e] = ldu_dq_pkg::LDU_LB;
            for (int w = 0; w < ldu_dq_pkg::DISPATCH_WAYS; w++) begin
                if (one_hot_by_way[w][e]) begin
                    dispatch_valid_by_entry[e]     |= 1'b1;
                    dispatch_op_by_entry[e]         = ldu_dq_pkg::ldu_op_e'(
                        dispatch_op_by_entry[e] | dispatch_op_by_way[w]);
                    dispatch_imm12_by_entry[e]     |= dispatch_imm12_by_way[w];
                    dispatch_A_PR_by_entry[e]      |= dispatch_A_PR_by_way[w];
                    dispatch_A_ready_by_entry[e]   |= dispatch_A_ready_by_way[w];
                    dispatch_A_is_zero_by_entry[e] |= dispatch_A_is_zero_by_way[w];
                    dispatch_dest_PR_by_entry[e]   |= dispatch_dest_PR_by_way[w];
                    dispatch_ROB_index_by_entry[e] |= dispatch_ROB_index_by_way[w];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/ldu_dq_pkg.sv
// ----------------------------------------------------------
// load unit dispatch queue package
// sizes, field types and the load opcode enum
// ----------------------------------------------------------
`default_nettype none

package ldu_dq_pkg;

    // queue and dispatch sizes
    localparam int DQ_ENTRIES         = 4;
    localparam int DISPATCH_WAYS      = 4;

    // register file, writeback and reorder buffer sizes
    localparam int LOG_PR_COUNT       = 7;
    localparam int LOG_PRF_BANK_COUNT = 2;
    localparam int PRF_BANK_COUNT     = 4;
    localparam int LOG_ROB_ENTRIES    = 7;
    localparam int IMM_WIDTH          = 12;

    // low bits of a PR pick the bank, upper bits are the tag
    typedef logic [LOG_PR_COUNT-1:0]                    pr_t;
    typedef logic [LOG_PR_COUNT-LOG_PRF_BANK_COUNT-1:0] upper_pr_t;
    typedef logic [LOG_ROB_ENTRIES-1:0]                 rob_index_t;
    typedef logic [IMM_WIDTH-1:0]                       imm12_t;
    typedef logic [DQ_ENTRIES-1:0]                      entry_mask_t;

    typedef enum logic [3:0] {
        LDU_LB  = 4'b0000,
        LDU_LH  = 4'b0001,
        LDU_LW  = 4'b0010,
        LDU_LBU = 4'b0100,
        LDU_LHU = 4'b0101
    } ldu_op_e;

endpackage

`default_nettype wire
